// File: realign_pkg.sv
/* fetch words are 32-bit and word aligned, always two 16-bit parcels per word
   addresses are byte addresses, bit 0 is assumed zero */
package realign_pkg;

    // default address width, the top level can narrow it to 32
    parameter int unsigned XLEN = 64;

    // one RVC parcel
    parameter int unsigned PARCEL_W = 16;

    // fetch word and emitted instruction share this width
    parameter int unsigned WORD_W = 32;

    // lower and upper parcel only
    parameter int unsigned PARCELS_PER_WORD = 2;

    // single parcel as it sits in the fetch word
    typedef logic [PARCEL_W-1:0] parcel_t;

    // fetch word, or an instruction after realignment
    // compressed ones are zero extended into the upper half
    typedef logic [WORD_W-1:0] word_t;

    // which parcel of the current word is being served
    // 0 = lower, 1 = upper
    typedef logic [$clog2(PARCELS_PER_WORD)-1:0] parcel_idx_t;

    // low opcode bits of a 32-bit instruction
    // anything else in bits [1:0] marks a compressed one
    parameter logic [1:0] RVC_OPCODE_FULL = 2'b11;

endpackage

// File: exc_pkg.sv
/* only the fetch side causes are listed here */
package exc_pkg;

    // mcause sized for RV64, upper bits stay zero
    typedef logic [63:0] cause_t;

    // no exception pending
    parameter cause_t CAUSE_NONE = 64'd0;

    // page fault on instruction fetch
    // tval then carries the faulting instruction address
    parameter cause_t CAUSE_INSTR_PAGE_FAULT = 64'd12;

endpackage

// File: parcel_decode.sv
/* purely combinational, looks at the word held by the fetch queue
   pending_i must reflect a buffered upper half from the previous word */
`timescale 1ns/1ps

module parcel_decode import realign_pkg::*; (
    // bit 1 of the fetch address, set after a jump to a half word
    input  logic                        fetch_addr_bit1_i,
    input  word_t                       fetch_data_i,
    // taken prediction per parcel
    input  logic [PARCELS_PER_WORD-1:0] fetch_taken_i,
    // a word crossing half is waiting in the buffer
    input  logic                        pending_i,
    output logic                        lo_emit_o,
    output logic                        lo_full_o,
    output logic                        hi_emit_o,
    output logic                        hi_stash_o
);

    parcel_t lo_parcel;
    parcel_t hi_parcel;
    logic    lo_comp;
    logic    hi_comp;
    logic    hi_blocked;

    // split the word
    assign lo_parcel = fetch_data_i[PARCEL_W-1:0];
    assign hi_parcel = fetch_data_i[WORD_W-1:PARCEL_W];

    // RVC check on the opcode bits
    assign lo_comp = (lo_parcel[1:0] != RVC_OPCODE_FULL);
    assign hi_comp = (hi_parcel[1:0] != RVC_OPCODE_FULL);

    // full aligned 32-bit instruction in this word
    // with a pending half the lower parcel is the tail of that one instead
    assign lo_full_o = ~fetch_addr_bit1_i & ~pending_i & ~lo_comp;

    // lower parcel always starts something or finishes the buffered half
    // skipped entirely on a half word start
    assign lo_emit_o = ~fetch_addr_bit1_i;

    // upper parcel is dead when
    //   the lower one is predicted taken
    //   it is just the second half of an aligned full instruction
    assign hi_blocked = (lo_emit_o & fetch_taken_i[0]) | lo_full_o;

    // compressed upper parcel, served on its own
    assign hi_emit_o = ~hi_blocked & hi_comp;

    // start of a word crossing instruction, goes to the buffer
    assign hi_stash_o = ~hi_blocked & ~hi_comp;

endmodule

// File: unaligned_buffer.sv
/* holds one upper half of a word crossing instruction
   load wins over consume, flush wins over both */
`timescale 1ns/1ps

module unaligned_buffer import realign_pkg::*; #(
    parameter int unsigned ADDR_W = XLEN
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    // capture the upper parcel of the current word
    input  logic              load_i,
    // buffered half was joined or thrown away
    input  logic              consume_i,
    input  parcel_t           parcel_i,
    // address of the current fetch word
    input  logic [ADDR_W-1:0] addr_i,
    output logic              pending_o,
    output parcel_t           parcel_o,
    output logic [ADDR_W-1:0] addr_o
);

    logic              pending_q;
    parcel_t           parcel_q;
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] half_addr;

    // the stored half always sits at word address + 2
    assign half_addr = {addr_i[ADDR_W-1:2], 2'b10};

    // valid flag
    always_ff @(posedge clk_i) begin
        if (!rst_ni || flush_i) begin
            pending_q <= 1'b0;
        end else if (load_i) begin
            pending_q <= 1'b1;
        end else if (consume_i) begin
            pending_q <= 1'b0;
        end
    end

    // payload, only meaningful while pending
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            parcel_q <= parcel_i;
            addr_q   <= half_addr;
        end
    end

    assign pending_o = pending_q;
    assign parcel_o  = parcel_q;
    assign addr_o    = addr_q;

endmodule

// File: realign_ctrl.sv
/* upstream must hold the word stable until fetch_ack_o, all outputs are combinational
   state only moves on an accepted transfer, a stash only word or a flush */
`timescale 1ns/1ps

module realign_ctrl import realign_pkg::*, exc_pkg::*; #(
    parameter int unsigned ADDR_W = XLEN
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    // fetch queue side
    input  logic                        fetch_valid_i,
    input  logic [ADDR_W-1:0]           fetch_addr_i,
    input  word_t                       fetch_data_i,
    input  logic [PARCELS_PER_WORD-1:0] fetch_taken_i,
    input  logic                        fetch_page_fault_i,
    output logic                        fetch_ack_o,
    // decoder side
    output logic                        instr_valid_o,
    output word_t                       instr_o,
    output logic [ADDR_W-1:0]           instr_addr_o,
    output logic                        bp_valid_o,
    output logic                        ex_valid_o,
    output cause_t                      ex_cause_o,
    output logic [ADDR_W-1:0]           ex_tval_o,
    input  logic                        instr_ack_i,
    // parcel classification
    input  logic                        lo_emit_i,
    input  logic                        lo_full_i,
    input  logic                        hi_emit_i,
    input  logic                        hi_stash_i,
    // buffered upper half
    input  logic                        pending_i,
    input  parcel_t                     pend_parcel_i,
    input  logic [ADDR_W-1:0]           pend_addr_i,
    output logic                        load_o,
    output logic                        consume_o
);

    parcel_idx_t       idx_d;
    parcel_idx_t       idx_q;
    parcel_t           lo_parcel;
    parcel_t           hi_parcel;
    logic [ADDR_W-1:0] word_addr;
    logic [ADDR_W-1:0] hi_addr;
    logic              serve_hi;
    logic              more_left;
    logic              accept;

    assign lo_parcel = fetch_data_i[PARCEL_W-1:0];
    assign hi_parcel = fetch_data_i[WORD_W-1:PARCEL_W];
    assign word_addr = {fetch_addr_i[ADDR_W-1:2], 2'b00};
    assign hi_addr   = {fetch_addr_i[ADDR_W-1:2], 2'b10};

    // upper parcel is up once the lower is done, or when the lower is skipped
    assign serve_hi  = (idx_q == parcel_idx_t'(1)) | ~lo_emit_i;
    // second compressed instruction still waiting in this word
    assign more_left = ~serve_hi & hi_emit_i;
    assign accept    = instr_valid_o & instr_ack_i;

    // output selection
    always_comb begin
        if (serve_hi) begin
            // compressed upper parcel
            instr_valid_o = fetch_valid_i & hi_emit_i;
            instr_o       = {{PARCEL_W{1'b0}}, hi_parcel};
            instr_addr_o  = hi_addr;
            bp_valid_o    = fetch_taken_i[1];
        end else if (pending_i) begin
            // buffered half plus lower parcel, ends in this word
            instr_valid_o = fetch_valid_i & lo_emit_i;
            instr_o       = {lo_parcel, pend_parcel_i};
            instr_addr_o  = pend_addr_i;
            bp_valid_o    = fetch_taken_i[0];
        end else if (lo_full_i) begin
            // aligned 32-bit, ends in the upper parcel
            instr_valid_o = fetch_valid_i & lo_emit_i;
            instr_o       = fetch_data_i;
            instr_addr_o  = word_addr;
            bp_valid_o    = fetch_taken_i[1];
        end else begin
            // compressed lower parcel
            instr_valid_o = fetch_valid_i & lo_emit_i;
            instr_o       = {{PARCEL_W{1'b0}}, lo_parcel};
            instr_addr_o  = word_addr;
            bp_valid_o    = fetch_taken_i[0];
        end
    end

    // acknowledges and next index
    always_comb begin
        idx_d       = idx_q;
        fetch_ack_o = 1'b0;
        load_o      = 1'b0;
        if (more_left) begin
            // keep the word, move on to the upper parcel
            if (accept) begin
                idx_d = parcel_idx_t'(1);
            end
        end else if (instr_valid_o) begin
            // last instruction of the word
            fetch_ack_o = accept;
            load_o      = accept & hi_stash_i;
            if (accept) begin
                idx_d = parcel_idx_t'(0);
            end
        end else begin
            // half word start into a 32-bit instruction, nothing to emit yet
            fetch_ack_o = fetch_valid_i & hi_stash_i;
            load_o      = fetch_ack_o;
        end
        // any word leaving with a half buffered has joined or dropped it
        consume_o = fetch_ack_o & pending_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni || flush_i) begin
            idx_q <= parcel_idx_t'(0);
        end else begin
            idx_q <= idx_d;
        end
    end

    // fault belongs to the word, tval is the address actually emitted
    assign ex_valid_o = instr_valid_o & fetch_page_fault_i;
    assign ex_cause_o = ex_valid_o ? CAUSE_INSTR_PAGE_FAULT : CAUSE_NONE;
    assign ex_tval_o  = instr_addr_o;

endmodule

// File: instr_realigner.sv
/* sits between fetch queue and decoder, one instruction per accepted handshake
   fetch words must be 32-bit aligned, a half word start is marked by address bit 1 */
`timescale 1ns/1ps

module instr_realigner import realign_pkg::*, exc_pkg::*; #(
    parameter int unsigned ADDR_W = XLEN
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    // from fetch queue
    input  logic                        fetch_valid_i,
    input  logic [ADDR_W-1:0]           fetch_addr_i,
    input  word_t                       fetch_data_i,
    input  logic [PARCELS_PER_WORD-1:0] fetch_taken_i,
    input  logic                        fetch_page_fault_i,
    output logic                        fetch_ack_o,
    // to decoder
    output logic                        instr_valid_o,
    output word_t                       instr_o,
    output logic [ADDR_W-1:0]           instr_addr_o,
    output logic                        bp_valid_o,
    output logic                        ex_valid_o,
    output cause_t                      ex_cause_o,
    output logic [ADDR_W-1:0]           ex_tval_o,
    input  logic                        instr_ack_i
);

    logic              lo_emit;
    logic              lo_full;
    logic              hi_emit;
    logic              hi_stash;
    logic              pending;
    parcel_t           pend_parcel;
    logic [ADDR_W-1:0] pend_addr;
    logic              load;
    logic              consume;

    // classify both parcels
    parcel_decode u_decode (
        .fetch_addr_bit1_i ( fetch_addr_i[1] ),
        .fetch_data_i      ( fetch_data_i    ),
        .fetch_taken_i     ( fetch_taken_i   ),
        .pending_i         ( pending         ),
        .lo_emit_o         ( lo_emit         ),
        .lo_full_o         ( lo_full         ),
        .hi_emit_o         ( hi_emit         ),
        .hi_stash_o        ( hi_stash        )
    );

    // upper half of a word crossing instruction
    unaligned_buffer #(
        .ADDR_W ( ADDR_W )
    ) u_buffer (
        .clk_i     ( clk_i                              ),
        .rst_ni    ( rst_ni                             ),
        .flush_i   ( flush_i                            ),
        .load_i    ( load                               ),
        .consume_i ( consume                            ),
        .parcel_i  ( fetch_data_i[WORD_W-1:PARCEL_W]    ),
        .addr_i    ( fetch_addr_i                       ),
        .pending_o ( pending                            ),
        .parcel_o  ( pend_parcel                        ),
        .addr_o    ( pend_addr                          )
    );

    realign_ctrl #(
        .ADDR_W ( ADDR_W )
    ) u_ctrl (
        .clk_i              ( clk_i              ),
        .rst_ni             ( rst_ni             ),
        .flush_i            ( flush_i            ),
        .fetch_valid_i      ( fetch_valid_i      ),
        .fetch_addr_i       ( fetch_addr_i       ),
        .fetch_data_i       ( fetch_data_i       ),
        .fetch_taken_i      ( fetch_taken_i      ),
        .fetch_page_fault_i ( fetch_page_fault_i ),
        .fetch_ack_o        ( fetch_ack_o        ),
        .instr_valid_o      ( instr_valid_o      ),
        .instr_o            ( instr_o            ),
        .instr_addr_o       ( instr_addr_o       ),
        .bp_valid_o         ( bp_valid_o         ),
        .ex_valid_o         ( ex_valid_o         ),
        .ex_cause_o         ( ex_cause_o         ),
        .ex_tval_o          ( ex_tval_o          ),
        .instr_ack_i        ( instr_ack_i        ),
        .lo_emit_i          ( lo_emit            ),
        .lo_full_i          ( lo_full            ),
        .hi_emit_i          ( hi_emit            ),
        .hi_stash_i         ( hi_stash           ),
        .pending_i          ( pending            ),
        .pend_parcel_i      ( pend_parcel        ),
        .pend_addr_i        ( pend_addr          ),
        .load_o             ( load               ),
        .consume_o          ( consume            )
    );

endmodule

// File: tb_realign_model.svh
/* expected transfer stream of the realigner, built from the fetch program
   needs the prog_* arrays and exp_* queues of the including module */
`ifndef TB_REALIGN_MODEL_SVH
`define TB_REALIGN_MODEL_SVH

// one expected transfer, the fetch ack flag is patched in later
function automatic void push_expected(input word_t instr, input logic [ADDR_W-1:0] addr,
                                      input logic bp, input logic fault, input string name);
    exp_instr.push_back(instr);
    exp_addr.push_back(addr);
    exp_bp.push_back(bp);
    exp_fault.push_back(fault);
    exp_last.push_back(1'b0);
    exp_name.push_back(name);
endfunction

// walk the parcels of every word in program order
function automatic void expand_program();
    logic              held;
    parcel_t           held_parcel;
    logic [ADDR_W-1:0] held_addr;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] upper;
    parcel_t           parcel;
    int                p;
    int                emitted;
    int                limit;
    held        = 1'b0;
    held_parcel = '0;
    held_addr   = '0;
    for (int w = 0; w < N_WORDS; w++) begin
        base    = {prog_addr[w][ADDR_W-1:2], 2'b00};
        upper   = {prog_addr[w][ADDR_W-1:2], 2'b10};
        p       = prog_addr[w][1] ? 1 : 0;
        emitted = 0;
        // a flushed word only gets its first instruction out
        limit   = prog_flush[w] ? 1 : 2;
        // jump to a half word, nothing held survives it
        if (prog_addr[w][1]) begin
            held = 1'b0;
        end
        while (p < 2 && emitted < limit) begin
            parcel = (p == 1) ? prog_data[w][31:16] : prog_data[w][15:0];
            if (held) begin
                // lower parcel ends the word crossing instruction
                push_expected({parcel, held_parcel}, held_addr, prog_taken[w][0],
                              prog_fault[w], prog_kind[w]);
                held = 1'b0;
                emitted++;
                p = prog_taken[w][0] ? 2 : 1;
            end else if (parcel[1:0] != 2'b11) begin
                // compressed, flag comes from this very parcel
                push_expected({{PARCEL_W{1'b0}}, parcel}, (p == 1) ? upper : base,
                              prog_taken[w][p], prog_fault[w], prog_kind[w]);
                emitted++;
                p = prog_taken[w][p] ? 2 : p + 1;
            end else if (p == 0) begin
                // aligned 32-bit, ends in the upper parcel
                push_expected(prog_data[w], base, prog_taken[w][1], prog_fault[w],
                              prog_kind[w]);
                emitted++;
                p = 2;
            end else begin
                // upper half waits for the next word
                held        = 1'b1;
                held_parcel = parcel;
                held_addr   = upper;
                p           = 2;
            end
        end
        // fetch ack comes with the last transfer of a word
        if (emitted > 0 && !prog_flush[w]) begin
            exp_last[exp_last.size() - 1] = 1'b1;
        end
    end
endfunction

`endif

// File: tb_instr_realigner.sv
/* random fetch program with a fixed seed, checked transfer by transfer at the falling edge
   a flush is only issued right after the first instruction of a two compressed word */
`timescale 1ns/1ps

module tb_instr_realigner import realign_pkg::*, exc_pkg::*; ();

    localparam int unsigned ADDR_W  = XLEN;
    localparam int unsigned N_WORDS = 400;
    localparam int unsigned CLK_NS  = 8;

    logic clk_i, rst_ni, flush_i, fetch_valid_i, fetch_page_fault_i, fetch_ack_o;
    logic [ADDR_W-1:0] fetch_addr_i, instr_addr_o, ex_tval_o;
    word_t fetch_data_i, instr_o;
    logic [PARCELS_PER_WORD-1:0] fetch_taken_i;
    logic instr_valid_o, bp_valid_o, ex_valid_o, instr_ack_i, feeder_done;
    cause_t ex_cause_o;
    integer seed;

    // program as the fetch queue will present it
    logic [ADDR_W-1:0] prog_addr  [N_WORDS];
    word_t             prog_data  [N_WORDS];
    logic [1:0]        prog_taken [N_WORDS];
    logic              prog_fault [N_WORDS];
    logic              prog_flush [N_WORDS];
    string             prog_kind  [N_WORDS];

    // expected transfers in order
    word_t exp_instr[$];
    logic [ADDR_W-1:0] exp_addr[$];
    logic exp_bp[$], exp_fault[$], exp_last[$];
    string exp_name[$];

    `include "tb_realign_model.svh"

    instr_realigner #(.ADDR_W(ADDR_W)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic word_check(input string name, input string what, input word_t e,
                              input word_t a);
        if (e !== a) begin
            abort_run($sformatf("** Error %s %s expected %h actual %h", name, what, e, a));
        end
    endtask

    task automatic addr_check(input string name, input string what, input logic [ADDR_W-1:0] e,
                              input logic [ADDR_W-1:0] a);
        if (e !== a) begin
            abort_run($sformatf("** Error %s %s expected %h actual %h", name, what, e, a));
        end
    endtask

    task automatic cause_check(input string name, input string what, input cause_t e,
                               input cause_t a);
        if (e !== a) begin
            abort_run($sformatf("** Error %s %s expected %0d actual %0d", name, what, e, a));
        end
    endtask

    task automatic flag_check(input string name, input string what, input logic e, input logic a);
        if (e !== a) begin
            abort_run($sformatf("** Error %s %s expected %b actual %b", name, what, e, a));
        end
    endtask

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // any opcode bits but 2'b11
    function automatic parcel_t rvc_parcel();
        parcel_t p;
        p = parcel_t'($random(seed));
        if (p[1:0] == 2'b11) p[1:0] = 2'b01;
        return p;
    endfunction

    // first half of a 32-bit instruction
    function automatic parcel_t full_head_parcel();
        parcel_t p;
        p = parcel_t'($random(seed));
        p[1:0] = 2'b11;
        return p;
    endfunction

    task automatic build_program();
        logic [ADDR_W-1:0] pc;
        logic carry, jump, half, stash;
        parcel_t lo, hi;
        logic [1:0] tk;
        string kind;
        int unsigned sel;
        pc    = ADDR_W'(64'h8000_0000);
        carry = 1'b0;
        half  = 1'b0;
        for (int i = 0; i < N_WORDS; i++) begin
            lo = rvc_parcel();
            hi = rvc_parcel();
            tk = 2'b00;
            sel = pick(8);
            jump = 1'b0;
            stash = 1'b0;
            prog_flush[i] = 1'b0;
            if (i < 12) begin
                kind = "aligned32";
                lo = full_head_parcel();
            end else if (carry) begin
                // lower parcel is the tail of the held half
                kind = "crossing";
                lo = parcel_t'($random(seed));
                if (sel < 2) begin
                    kind = "taken";
                    tk[0] = 1'b1;
                    jump = 1'b1;
                end else if (sel < 5) begin
                    hi = full_head_parcel();
                    stash = 1'b1;
                end
            end else if (half) begin
                // lower parcel is skipped, any value
                kind = "half_start";
                lo = parcel_t'($random(seed));
                if (sel < 3) begin
                    hi = full_head_parcel();
                    stash = 1'b1;
                end else if (sel == 3) begin
                    tk[1] = 1'b1;
                    jump = 1'b1;
                end
            end else if (sel < 2) begin
                kind = "aligned32";
                lo = full_head_parcel();
                tk[1] = (sel == 1);
                jump = (sel == 1);
            end else if (sel == 2 && i < N_WORDS - 2) begin
                kind = "flush";
                prog_flush[i] = 1'b1;
                jump = 1'b1;
            end else if (sel == 3) begin
                kind = "taken";
                tk[0] = 1'b1;
                jump = 1'b1;
            end else if (sel < 6) begin
                kind = "two_rvc";
                tk[1] = (sel == 5);
                jump = (sel == 5);
            end else begin
                kind = "crossing";
                hi = full_head_parcel();
                stash = 1'b1;
            end
            prog_addr[i]  = {pc[ADDR_W-1:2], half, 1'b0};
            prog_data[i]  = {hi, lo};
            prog_taken[i] = tk;
            prog_fault[i] = (pick(10) == 0);
            prog_kind[i]  = kind;
            carry = stash;
            if (jump) begin
                // redirect to some word, half of them at bit 1
                pc   = ADDR_W'(64'h8000_0000) + (ADDR_W'(pick(4096)) << 2);
                half = (pick(2) == 1);
            end else begin
                pc   = pc + ADDR_W'(4);
                half = 1'b0;
            end
        end
    endtask

    initial begin
        rst_ni = 1'b0;
        flush_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i = '0;
        fetch_data_i = '0;
        fetch_taken_i = '0;
        fetch_page_fault_i = 1'b0;
        instr_ack_i = 1'b0;
        feeder_done = 1'b0;
        seed = 32'h846e50cc;
        build_program();
        expand_program();
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        wait (feeder_done === 1'b1);
        repeat (4) @(posedge clk_i);
        if (exp_instr.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected instructions never came out", exp_instr.size()));
        end
    end

    // fetch queue, holds each word until acknowledged
    initial begin : feeder
        logic done;
        logic do_flush;
        wait (rst_ni === 1'b1);
        for (int i = 0; i < N_WORDS; i++) begin
            fetch_valid_i = 1'b1;
            fetch_addr_i = prog_addr[i];
            fetch_data_i = prog_data[i];
            fetch_taken_i = prog_taken[i];
            fetch_page_fault_i = prog_fault[i];
            done = 1'b0;
            do_flush = 1'b0;
            while (!done) begin
                @(negedge clk_i);
                if (fetch_ack_o) begin
                    done = 1'b1;
                end else if (prog_flush[i] && instr_valid_o && instr_ack_i) begin
                    done = 1'b1;
                    do_flush = 1'b1;
                end
                @(posedge clk_i);
                #1;
            end
            if (do_flush) begin
                // queue drops the word along with the realigner
                fetch_valid_i = 1'b0;
                flush_i = 1'b1;
                @(posedge clk_i);
                #1;
                flush_i = 1'b0;
            end
        end
        fetch_valid_i = 1'b0;
        feeder_done = 1'b1;
    end

    // decoder stalls about one cycle in four
    initial begin : ack_driver
        wait (rst_ni === 1'b1);
        forever begin
            instr_ack_i = (pick(4) != 0);
            @(posedge clk_i);
            #1;
        end
    end

    // one expected item per accepted transfer
    initial begin : transfer_compare
        word_t e_instr;
        logic [ADDR_W-1:0] e_addr;
        logic e_bp, e_fault, e_last;
        string name;
        forever begin
            @(negedge clk_i);
            if (instr_valid_o && !fetch_valid_i) begin
                abort_run("instruction valid with no fetch word");
            end
            if (instr_valid_o && instr_ack_i) begin
                if (exp_instr.size() == 0) begin
                    abort_run("more instructions came out than expected");
                end
                e_instr = exp_instr.pop_front();
                e_addr = exp_addr.pop_front();
                e_bp = exp_bp.pop_front();
                e_fault = exp_fault.pop_front();
                e_last = exp_last.pop_front();
                name = exp_name.pop_front();
                word_check(name, "instr_o", e_instr, instr_o);
                addr_check(name, "instr_addr_o", e_addr, instr_addr_o);
                flag_check(name, "bp_valid_o", e_bp, bp_valid_o);
                flag_check(name, "ex_valid_o", e_fault, ex_valid_o);
                cause_check(name, "ex_cause_o", e_fault ? CAUSE_INSTR_PAGE_FAULT : CAUSE_NONE,
                            ex_cause_o);
                addr_check(name, "ex_tval_o", e_addr, ex_tval_o);
                flag_check(name, "fetch_ack_o", e_last, fetch_ack_o);
            end
        end
    end

    initial begin : watchdog
        #((N_WORDS * 4 * CLK_NS * 2) + (20 * CLK_NS));
        abort_run("watchdog expired, the realigner stopped making progress");
    end

endmodule

// File: instr_realigner.f
+incdir+.
realign_pkg.sv
exc_pkg.sv
parcel_decode.sv
unaligned_buffer.sv
realign_ctrl.sv
instr_realigner.sv
tb_instr_realigner.sv

// File: Makefile
# Verilator flow for the instruction realigner testbench
# a failing run ends in $fatal, so make sees a non-zero exit status

VERILATOR ?= verilator
TOP       := tb_instr_realigner
FILELIST  := instr_realigner.f
OBJ_DIR   := obj_dir
VFLAGS    := --timing --top-module $(TOP) -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
